/* colourMapper.sv */
`timescale 1ns/1ps

module colourMapper (
   input  logic                  clk7,
   input  logic                  rst_n,
   input  logic                  pixelBit,
   input  ulaVideoPkg::attrT     attrOut,
   input  logic                  videoOn,
   input  logic                  plusEnable,
   input  logic                  palWe,
   input  ulaCpuPkg::paletteIdxT palWrIdx,
   input  ulaCpuPkg::byteT       palWrData,
   output ulaCpuPkg::byteT       palRdData,
   output logic [2:0]            r,
   output logic [2:0]            g,
   output logic [2:0]            b
);
   import ulaVideoPkg::*;
   import ulaCpuPkg::*;

   // Per-channel output levels
   localparam logic [2:0] levelNone = 3'b000;
   localparam logic [2:0] levelHalf = 3'b101;
   localparam logic [2:0] levelFull = 3'b111;

   byteT       palette [64];
   logic       inkOn;
   logic [3:0] igrb;
   logic [2:0] level;
   colourT     stdColour;
   paletteIdxT plusIdx;
   byteT       plusEntry;
   colourT     plusColour;
   colourT     finalColour;

   // Ink only inside paper cells
   assign inkOn = pixelBit & videoOn;

   ////////////////////////////////////////
   // Standard IGRB path
   ////////////////////////////////////////

   assign igrb  = {attrOut.std.bright, inkOn ? attrOut.std.ink : attrOut.std.paper};
   assign level = igrb[3] ? levelFull : levelHalf;

   // Off channels stay at none, so bright black is still black
   assign stdColour = {igrb[2] ? level : levelNone,
                       igrb[1] ? level : levelNone,
                       igrb[0] ? level : levelNone};

   ////////////////////////////////////////
   // ULAplus path
   ////////////////////////////////////////

   // Held off while in reset
   always_ff @(posedge clk7) begin
      if (rst_n && palWe) begin
         palette[palWrIdx] <= palWrData;
      end
   end

   // CPU readback shares the write index
   assign palRdData = palette[palWrIdx];

   // Paper entries sit at 8..15 of each CLUT, ink at 0..7
   assign plusIdx   = {attrOut.plus.clut, ~inkOn,
                       inkOn ? attrOut.plus.ink : attrOut.plus.paper};
   assign plusEntry = palette[plusIdx];
   // GGGRRRBB to 9 bits, blue MSB copied into the new LSB
   assign plusColour = {plusEntry, plusEntry[1]};

   assign finalColour = plusEnable ? plusColour : stdColour;

   assign g = finalColour[8:6];
   assign r = finalColour[5:3];
   assign b = finalColour[2:0];

endmodule

/* cpuPorts.sv */
`timescale 1ns/1ps

module cpuPorts #(
   parameter logic [2:0] borderReset = 3'b010
) (
   input  logic                  clk7,
   input  logic                  rst_n,
   input  logic [15:0]           a,
   input  logic                  iorqN,
   input  logic                  rdN,
   input  logic                  wrN,
   input  ulaCpuPkg::byteT       din,
   input  logic                  ear,
   input  logic [4:0]            kbd,
   input  logic                  issue2Keyboard,
   input  ulaCpuPkg::byteT       palRdData,
   output ulaCpuPkg::byteT       dout,
   output logic [2:0]            border,
   output logic                  mic,
   output logic                  spk,
   output logic                  plusEnable,
   output logic                  palWe,
   output ulaCpuPkg::paletteIdxT palWrIdx,
   output ulaCpuPkg::byteT       palWrData
);
   import ulaCpuPkg::*;

   // Low byte that shares a[0]=0 but belongs to another device
   localparam logic [7:0] feExcluded = 8'hF4;

   logic    ioWr;
   logic    ioRd;
   logic    feSel;
   logic    plusAddrSel;
   logic    plusDataSel;
   logic    earIn;
   plusSelT plusSel;

   ////////////////////////////////////////
   // Port decode and writes
   ////////////////////////////////////////

   assign ioWr        = !iorqN && !wrN;
   assign ioRd        = !iorqN && !rdN;
   assign feSel       = !a[0] && (a[7:0] != feExcluded);
   assign plusAddrSel = (a == plusAddrPort);
   assign plusDataSel = (a == plusDataPort);

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border     <= borderReset;
         mic        <= 1'b0;
         spk        <= 1'b0;
         plusSel    <= '0;
         plusEnable <= 1'b0;
      end else if (ioWr) begin
         // 0xFE layout is ---SMBBB
         if (feSel) begin
            border <= din[2:0];
            mic    <= din[3];
            spk    <= din[4];
         end else if (plusAddrSel) begin
            plusSel <= din[6:0];
         end else if (plusDataSel && plusSel[plusCfgBit]) begin
            plusEnable <= din[plusEnableBit];
         end
      end
   end

   // Palette group of the data port goes straight to the RAM
   assign palWe     = ioWr && plusDataSel && !plusSel[plusCfgBit];
   assign palWrIdx  = plusSel[5:0];
   assign palWrData = din;

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   // Issue 2 boards also leak MIC onto EAR
   always_comb begin
      if (issue2Keyboard) begin
         earIn = ear ^ (spk | mic);
      end else begin
         earIn = ear ^ spk;
      end
   end

   always_comb begin
      dout = 8'hFF;
      if (ioRd) begin
         if (feSel) begin
            dout = {1'b1, earIn, 1'b1, kbd};
         end else if (plusAddrSel) begin
            dout = {1'b0, plusSel};
         end else if (plusDataSel && !plusSel[plusCfgBit]) begin
            dout = palRdData;
         end else if (plusDataSel) begin
            dout = {7'b0000000, plusEnable};
         end
      end
   end

endmodule

/* project.f */
ulaVideoPkg.sv
ulaCpuPkg.sv
rasterTiming.sv
screenFetch.sv
colourMapper.sv
cpuPorts.sv
ulaTop.sv
ulaTop_properties.sv
ulaTb.sv

/* rasterTiming.sv */
`timescale 1ns/1ps

module rasterTiming (
   input  logic                clk7,
   input  logic                rst_n,
   output ulaVideoPkg::hCountT hCount,
   output ulaVideoPkg::vCountT vCount,
   output logic                paperArea,
   output logic                flashTick,
   output logic                hsync,
   output logic                vsync,
   output logic                intN
);
   import ulaVideoPkg::*;

   // Sync pulse positions
   localparam hCountT hsyncStart = 9'd344;
   localparam hCountT hsyncEnd   = 9'd375;
   // Four lines of vsync
   localparam vCountT vsyncEnd   = vCountT'(vsyncLine + 3);

   logic lineEnd;
   logic frameEnd;
   logic intLine;

   assign lineEnd  = (hCount == hCountT'(lineLength - 1));
   assign frameEnd = (vCount == vCountT'(frameLines - 1));

   // Pixel counter wraps into the line counter
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hCount <= '0;
         vCount <= '0;
      end else if (lineEnd) begin
         hCount <= '0;
         if (frameEnd) begin
            vCount <= '0;
         end else begin
            vCount <= vCount + 9'd1;
         end
      end else begin
         hCount <= hCount + 9'd1;
      end
   end

   // Interrupt and flash both key off the first vsync line
   assign intLine   = (vCount == vCountT'(vsyncLine));
   assign flashTick = intLine && (hCount == '0);
   // Low for the first intLength clocks of that line
   assign intN      = !(intLine && (hCount < hCountT'(intLength)));

   assign hsync = (hCount >= hsyncStart) && (hCount <= hsyncEnd);
   assign vsync = (vCount >= vCountT'(vsyncLine)) && (vCount <= vsyncEnd);

   // Fetch window, not yet delayed for the serializer
   assign paperArea = (hCount < hCountT'(paperWidth)) && (vCount < vCountT'(paperHeight));

endmodule

/* run.sh */
#!/bin/sh
# Build the ULA testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module ulaTb -f project.f -o ulaSim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi

./obj_dir/ulaSim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed"
   exit $status
fi

exit 0

/* screenFetch.sv */
`timescale 1ns/1ps

module screenFetch (
   input  logic                clk7,
   input  logic                rst_n,
   input  ulaVideoPkg::hCountT hCount,
   input  ulaVideoPkg::vCountT vCount,
   input  logic                paperArea,
   input  logic                flashTick,
   input  logic [2:0]          border,
   input  ulaCpuPkg::byteT     vramData,
   output logic [13:0]         va,
   output logic                vramRd,
   output logic                pixelBit,
   output ulaVideoPkg::attrT   attrOut,
   output logic                videoOn
);
   import ulaVideoPkg::*;
   import ulaCpuPkg::*;

   logic       bitmapAddr;
   logic       attrAddr;
   logic       bitmapLoad;
   logic       attrLoad;
   logic       colLoad;
   logic       cellLoad;
   logic       paperDelayed;
   logic [4:0] col;
   logic [4:0] flashCount;
   byteT       bitmapData;
   byteT       attrData;
   byteT       shifter;
   attrT       attrNext;

   ////////////////////////////////////////
   // Fetch control unit
   ////////////////////////////////////////

   // Paper window shifted right by one cell for the shifter
   assign paperDelayed = (hCount >= hCountT'(8)) && (hCount < hCountT'(paperWidth + 8))
                         && (vCount < vCountT'(paperHeight));

   // Column register follows hCount three clocks into each cell
   assign colLoad  = (hCount[2:0] == 3'd3);
   // Shifter and attribute output step once per cell
   assign cellLoad = (hCount[2:0] == 3'd4);

   always_comb begin
      bitmapAddr = 1'b0;
      attrAddr   = 1'b0;
      bitmapLoad = 1'b0;
      attrLoad   = 1'b0;
      // Two bitmap/attribute pairs in the upper half of each 16-clock group
      if (paperArea && hCount[3]) begin
         case (hCount[1:0])
            2'd0: bitmapAddr = 1'b1;
            2'd1: begin
               bitmapAddr = 1'b1;
               bitmapLoad = 1'b1;
            end
            2'd2: attrAddr = 1'b1;
            default: begin
               attrAddr = 1'b1;
               attrLoad = 1'b1;
            end
         endcase
      end
   end

   assign vramRd = bitmapAddr | attrAddr;

   // Bitmap rows interleaved by third, pixel row and char row
   // Attribute map starts at 0x1800, one byte per char cell
   always_comb begin
      if (attrAddr) begin
         va = {1'b0, 3'b110, vCount[7:3], col};
      end else begin
         va = {1'b0, vCount[7:6], vCount[2:0], vCount[5:3], col};
      end
   end

   ////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////

   // Border cells carry the border colour as paper, no flash
   always_comb begin
      if (paperDelayed) begin
         attrNext = attrData;
      end else begin
         attrNext.std.flash  = 1'b0;
         attrNext.std.bright = 1'b0;
         attrNext.std.paper  = border;
         attrNext.std.ink    = 3'b000;
      end
   end

   always_ff @(posedge clk7) begin
      if (colLoad) begin
         col <= hCount[7:3];
      end
      if (bitmapLoad) begin
         bitmapData <= vramData;
      end
      if (attrLoad) begin
         attrData <= vramData;
      end
      // MSB first, zeros fill in behind
      if (cellLoad && paperDelayed) begin
         shifter <= bitmapData;
      end else begin
         shifter <= {shifter[6:0], 1'b0};
      end
      if (cellLoad) begin
         attrOut <= attrNext;
      end
   end

   // Frame counter and paper flag that travels with attrOut
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCount <= '0;
         videoOn    <= 1'b0;
      end else begin
         if (flashTick) begin
            flashCount <= flashCount + 5'd1;
         end
         if (cellLoad) begin
            videoOn <= paperDelayed;
         end
      end
   end

   // Flash swaps ink and paper every 16 frames
   assign pixelBit = shifter[7] ^ (attrOut.std.flash & flashCount[4]);

endmodule

/* ulaCpuPkg.sv */
package ulaCpuPkg;

   // ULAplus register select and data ports, full 16-bit decode
   localparam logic [15:0] plusAddrPort = 16'hBF3B;
   localparam logic [15:0] plusDataPort = 16'hFF3B;

   // Port 0xFE answers any I/O cycle with a[0] low
   // Low byte 0xF4 is left out of that decode

   // Z80 data bus
   typedef logic [7:0] byteT;

   // ULAplus palette holds 64 entries
   typedef logic [5:0] paletteIdxT;

   // Register select word written to plusAddrPort
   // Bit 6 set picks the config register
   // Bit 6 clear picks palette entry [5:0]
   typedef logic [6:0] plusSelT;

   // Position of the group bit inside plusSelT
   localparam int plusCfgBit = 6;

   // Config register layout
   // Only bit 0 is kept, the palette enable
   localparam int plusEnableBit = 0;

endpackage

/* ulaTb.sv */
`timescale 1ns/1ps

module ulaTb;
   import ulaVideoPkg::*;
   import ulaCpuPkg::*;

   // Longest wait is one full frame
   localparam int waitLimit = lineLength * frameLines + 16;

   logic        clk7;
   logic        rst_n;
   logic [15:0] a;
   logic        iorqN;
   logic        rdN;
   logic        wrN;
   byteT        din;
   byteT        dout;
   logic        ear;
   logic [4:0]  kbd;
   logic        issue2Keyboard;
   logic        mic;
   logic        spk;
   logic [13:0] va;
   logic        vramRd;
   byteT        vramData;
   logic [2:0]  r;
   logic [2:0]  g;
   logic [2:0]  b;
   logic        hsync;
   logic        vsync;
   logic        intN;

   hCountT      hModel;
   vCountT      vModel;
   logic        rasterCheckOn;
   integer      seed;
   byteT        testAttr;

   ulaTop uut (
      .clk7(clk7), .rst_n(rst_n), .a(a), .iorqN(iorqN), .rdN(rdN), .wrN(wrN),
      .din(din), .dout(dout), .ear(ear), .kbd(kbd), .issue2Keyboard(issue2Keyboard),
      .mic(mic), .spk(spk), .va(va), .vramRd(vramRd), .vramData(vramData),
      .r(r), .g(g), .b(b), .hsync(hsync), .vsync(vsync), .intN(intN)
   );

   initial begin
      clk7 = 1'b0;
      forever #4 clk7 = ~clk7;
   end

   // VRAM model, solid bitmap and one fixed attribute
   always_comb begin
      if (va < 14'h1800) begin
         vramData = 8'hFF;
      end else begin
         vramData = testAttr;
      end
   end

   ////////////////////////////////////////
   // Reference raster position
   ////////////////////////////////////////

   always @(posedge clk7) begin
      if (!rst_n) begin
         hModel <= '0;
         vModel <= '0;
      end else if (hModel == hCountT'(lineLength - 1)) begin
         hModel <= '0;
         vModel <= (vModel == vCountT'(frameLines - 1)) ? '0 : vModel + 9'd1;
      end else begin
         hModel <= hModel + 9'd1;
      end
   end

   task automatic abortRun();
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic mismatch(input string msg);
      $display("FAILED at time %0t: %s", $time, msg);
      abortRun();
   endtask

   task automatic timedOut(input string msg);
      $display("Timed out waiting for %s", msg);
      abortRun();
   endtask

   // Sync and interrupt against the reference position
   always @(negedge clk7) begin
      if (rasterCheckOn) begin
         assert (intN == !((vModel == vCountT'(vsyncLine)) && (hModel < hCountT'(intLength))))
            else mismatch($sformatf("intN %b at line %0d pixel %0d", intN, vModel, hModel));
         assert (hsync == ((hModel >= 9'd344) && (hModel <= 9'd375)))
            else mismatch($sformatf("hsync %b at pixel %0d", hsync, hModel));
         assert (vsync == ((vModel >= 9'd248) && (vModel <= 9'd251)))
            else mismatch($sformatf("vsync %b at line %0d", vsync, vModel));
      end
   end

   // Standard palette, each set channel at half or full level
   function automatic colourT igrbToColour(input logic bright, input logic [2:0] grb);
      logic [2:0] lvl;
      lvl = bright ? 3'b111 : 3'b101;
      return {grb[2] ? lvl : 3'b000, grb[1] ? lvl : 3'b000, grb[0] ? lvl : 3'b000};
   endfunction

   // GGGRRRBB with the blue high bit repeated
   function automatic colourT widenPlusEntry(input byteT entry);
      logic [2:0] grn;
      logic [2:0] red;
      logic [2:0] blu;
      grn = entry[7:5];
      red = entry[4:2];
      blu = {entry[1:0], entry[1]};
      return {grn, red, blu};
   endfunction

   ////////////////////////////////////////
   // Bus and raster tasks
   ////////////////////////////////////////

   task automatic writePort(input logic [15:0] addr, input byteT data);
      @(negedge clk7);
      a     = addr;
      din   = data;
      iorqN = 1'b0;
      wrN   = 1'b0;
      @(negedge clk7);
      iorqN = 1'b1;
      wrN   = 1'b1;
   endtask

   // Read data is combinational, taken just before the edge
   task automatic readPort(input logic [15:0] addr, output byteT data);
      @(negedge clk7);
      a     = addr;
      iorqN = 1'b0;
      rdN   = 1'b0;
      @(posedge clk7);
      data = dout;
      @(negedge clk7);
      iorqN = 1'b1;
      rdN   = 1'b1;
   endtask

   task automatic waitForPosition(input int line, input int pixel);
      int cycles;
      cycles = 0;
      while (!((vModel == vCountT'(line)) && (hModel == hCountT'(pixel)))) begin
         @(negedge clk7);
         cycles++;
         if (cycles > waitLimit) begin
            timedOut($sformatf("line %0d pixel %0d", line, pixel));
         end
      end
   endtask

   // Same colour on a run of consecutive pixels
   task automatic checkRun(input int line, input int pixel, input int count,
                           input colourT expected, input string what);
      waitForPosition(line, pixel);
      for (int n = 0; n < count; n++) begin
         assert ({g, r, b} == expected)
            else mismatch($sformatf("%s at line %0d pixel %0d, got %h, expected %h",
                                    what, vModel, hModel, {g, r, b}, expected));
         @(negedge clk7);
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin
      logic [31:0] rnd;
      byteT        data;
      byteT        entry;
      logic        earBit;
      logic [2:0]  borderColour;
      paletteIdxT  inkIdx;
      seed           = 32'h2d09_26cd;
      rst_n          = 1'b0;
      a              = 16'hFFFF;
      iorqN          = 1'b1;
      rdN            = 1'b1;
      wrN            = 1'b1;
      din            = 8'h00;
      ear            = 1'b0;
      kbd            = 5'h1F;
      issue2Keyboard = 1'b0;
      rasterCheckOn  = 1'b0;
      rnd            = $random(seed);
      // Flash clear, paper the complement of ink so the two never match
      testAttr       = {1'b0, rnd[6], ~rnd[2:0], rnd[2:0]};
      repeat (8) @(negedge clk7);
      rst_n         = 1'b1;
      rasterCheckOn = 1'b1;

      // Port 0xFE read with random MIC, speaker, EAR and keys
      for (int i = 0; i < 12; i++) begin
         rnd = $random(seed);
         writePort({rnd[31:24], 8'hFE}, rnd[7:0]);
         assert ((mic == rnd[3]) && (spk == rnd[4]))
            else mismatch($sformatf("mic %b spk %b after port FE write", mic, spk));
         ear            = rnd[8];
         kbd            = rnd[13:9];
         issue2Keyboard = rnd[14];
         earBit = issue2Keyboard ? (ear ^ (rnd[4] | rnd[3])) : (ear ^ rnd[4]);
         readPort({rnd[23:16], 8'hFE}, data);
         assert (data == {1'b1, earBit, 1'b1, kbd})
            else mismatch($sformatf("port FE read %h", data));
      end
      // Excluded low byte, keys held so a wrong decode cannot read all ones
      kbd = 5'h00;
      readPort(16'h00F4, data);
      assert (data == 8'hFF)
         else mismatch($sformatf("port F4 read %h", data));

      rnd          = $random(seed);
      // Away from the reset colour so the write is visible
      borderColour = (rnd[2:0] == 3'b010) ? 3'b101 : rnd[2:0];
      writePort(16'h00FE, {3'b000, rnd[4:3], borderColour});

      // Solid bitmap, so paper cells show ink
      checkRun(100, 64, 137, igrbToColour(testAttr[6], testAttr[2:0]), "standard ink");
      checkRun(200, 0, 40 * lineLength, igrbToColour(1'b0, borderColour), "border");

      // ULAplus register select and palette readback
      rnd = $random(seed);
      writePort(plusAddrPort, {2'b00, rnd[5:0]});
      readPort(plusAddrPort, data);
      assert (data == {2'b00, rnd[5:0]})
         else mismatch($sformatf("ULAplus select read %h", data));
      writePort(plusDataPort, rnd[15:8]);
      readPort(plusDataPort, data);
      assert (data == rnd[15:8])
         else mismatch($sformatf("palette entry read %h", data));

      // Config group, enable bit
      writePort(plusAddrPort, 8'h40);
      readPort(plusAddrPort, data);
      assert (data == 8'h40)
         else mismatch($sformatf("ULAplus config select read %h", data));
      writePort(plusDataPort, 8'h01);
      readPort(plusDataPort, data);
      assert (data == 8'h01)
         else mismatch($sformatf("ULAplus enable read %h", data));

      // Ink entry of the test attribute in its CLUT
      inkIdx = {testAttr[7:6], 1'b0, testAttr[2:0]};
      entry  = rnd[23:16];
      writePort(plusAddrPort, {2'b00, inkIdx});
      writePort(plusDataPort, entry);
      readPort(plusDataPort, data);
      assert (data == entry)
         else mismatch($sformatf("ink entry read %h", data));
      checkRun(100, 64, 137, widenPlusEntry(entry), "ULAplus ink");

      $display("TEST PASSED");
      $finish;
   end

endmodule

/* ulaTop.sv */
`timescale 1ns/1ps

module ulaTop #(
   parameter logic [2:0] borderReset = 3'b010
) (
   input  logic            clk7,
   input  logic            rst_n,
   input  logic [15:0]     a,
   input  logic            iorqN,
   input  logic            rdN,
   input  logic            wrN,
   input  ulaCpuPkg::byteT din,
   output ulaCpuPkg::byteT dout,
   input  logic            ear,
   input  logic [4:0]      kbd,
   input  logic            issue2Keyboard,
   output logic            mic,
   output logic            spk,
   output logic [13:0]     va,
   output logic            vramRd,
   input  ulaCpuPkg::byteT vramData,
   output logic [2:0]      r,
   output logic [2:0]      g,
   output logic [2:0]      b,
   output logic            hsync,
   output logic            vsync,
   output logic            intN
);
   import ulaVideoPkg::*;
   import ulaCpuPkg::*;

   // Raster position and window flags
   hCountT     hCount;
   vCountT     vCount;
   logic       paperArea;
   logic       flashTick;
   // Fetch to colour stage
   logic       pixelBit;
   attrT       attrOut;
   logic       videoOn;
   // CPU registers to video side
   logic [2:0] border;
   logic       plusEnable;
   logic       palWe;
   paletteIdxT palWrIdx;
   byteT       palWrData;
   byteT       palRdData;

   rasterTiming timing (
      .clk7(clk7), .rst_n(rst_n), .hCount(hCount), .vCount(vCount),
      .paperArea(paperArea), .flashTick(flashTick), .hsync(hsync),
      .vsync(vsync), .intN(intN)
   );

   screenFetch fetch (
      .clk7(clk7), .rst_n(rst_n), .hCount(hCount), .vCount(vCount),
      .paperArea(paperArea), .flashTick(flashTick), .border(border),
      .vramData(vramData), .va(va), .vramRd(vramRd), .pixelBit(pixelBit),
      .attrOut(attrOut), .videoOn(videoOn)
   );

   colourMapper colour (
      .clk7(clk7), .rst_n(rst_n), .pixelBit(pixelBit), .attrOut(attrOut),
      .videoOn(videoOn), .plusEnable(plusEnable), .palWe(palWe),
      .palWrIdx(palWrIdx), .palWrData(palWrData), .palRdData(palRdData),
      .r(r), .g(g), .b(b)
   );

   cpuPorts #(.borderReset(borderReset)) ports (
      .clk7(clk7), .rst_n(rst_n), .a(a), .iorqN(iorqN), .rdN(rdN), .wrN(wrN),
      .din(din), .ear(ear), .kbd(kbd), .issue2Keyboard(issue2Keyboard),
      .palRdData(palRdData), .dout(dout), .border(border), .mic(mic),
      .spk(spk), .plusEnable(plusEnable), .palWe(palWe),
      .palWrIdx(palWrIdx), .palWrData(palWrData)
   );

endmodule

/* ulaTop_properties.sv */
`timescale 1ns/1ps

module ulaTopProperties (
   input logic                clk7,
   input logic                rst_n,
   input ulaVideoPkg::hCountT hCount,
   input ulaVideoPkg::vCountT vCount,
   input logic [13:0]         va,
   input logic                vramRd,
   input logic                iorqN,
   input logic                rdN,
   input ulaCpuPkg::byteT     dout
);
   import ulaVideoPkg::*;

   logic bitmapOk;
   logic attrOk;

   // Bitmap map is third, pixel row, char row, column
   assign bitmapOk = (va < 14'h1800) && (va[12:11] == vCount[7:6])
                     && (va[10:8] == vCount[2:0]) && (va[7:5] == vCount[5:3]);
   // Attribute map holds one row of 32 cells per char row
   assign attrOk = (va >= 14'h1800) && (va <= 14'h1AFF) && (va[9:5] == vCount[7:3]);

   ////////////////////////////////////////
   // Raster counter
   ////////////////////////////////////////

   hCountStep: assert property (@(posedge clk7) disable iff (!rst_n)
      (hCount != hCountT'(lineLength - 1)) |=> (hCount == $past(hCount) + 9'd1))
      else $error("pixel counter skipped a step");

   ////////////////////////////////////////
   // VRAM fetch
   ////////////////////////////////////////

   fetchInPaper: assert property (@(posedge clk7) disable iff (!rst_n)
      vramRd |-> ((hCount < hCountT'(paperWidth)) && (vCount < vCountT'(paperHeight))))
      else $error("VRAM read outside the paper area");

   fetchAddress: assert property (@(posedge clk7) disable iff (!rst_n)
      vramRd |-> (bitmapOk || attrOk))
      else $error("VRAM address does not belong to the current line");

   // Bus floats high when no read is decoded
   idleBus: assert property (@(posedge clk7) disable iff (!rst_n)
      (iorqN || rdN) |-> (dout == 8'hFF))
      else $error("data bus driven without an I/O read");

endmodule

bind ulaTop ulaTopProperties props (
   .clk7(clk7), .rst_n(rst_n), .hCount(hCount), .vCount(vCount), .va(va),
   .vramRd(vramRd), .iorqN(iorqN), .rdN(rdN), .dout(dout)
);

/* ulaVideoPkg.sv */
package ulaVideoPkg;

   // Raster size in pixel clocks and lines
   localparam int lineLength = 448;
   localparam int frameLines = 312;

   // Visible paper window, top left at counter origin
   localparam int paperWidth  = 256;
   localparam int paperHeight = 192;

   // Line that opens vsync, the frame interrupt and the flash step
   localparam int vsyncLine = 248;
   // Interrupt pulse width in pixel clocks
   localparam int intLength = 32;

   // Final colour word, GGGRRRBBB
   typedef logic [8:0] colourT;

   // Raster counters
   typedef logic [8:0] hCountT;
   typedef logic [8:0] vCountT;

   // Attribute byte as seen by the standard ULA
   typedef struct packed {
      logic       flash;
      logic       bright;
      logic [2:0] paper;
      logic [2:0] ink;
   } stdAttrT;

   // Same byte as seen by ULAplus
   typedef struct packed {
      logic [1:0] clut;
      logic [2:0] paper;
      logic [2:0] ink;
   } plusAttrT;

   typedef union packed {
      stdAttrT  std;
      plusAttrT plus;
   } attrT;

endpackage
